/* filelist.f */
+incdir+rtl
rtl/corebus_pkg.sv
rtl/corebus_slice_stage.sv
rtl/corebus_slicer_chain.sv
rtl/corebus_slicer.sv
rtl/corebus_memory_target.sv
rtl/corebus_top.sv
tests/tb_corebus_top.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f filelist.f \
  --top-module tb_corebus_top -o tb_corebus_top

./obj_dir/tb_corebus_top > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported failure, see sim.log"
  exit 1
fi

echo "simulation finished without failure"
exit 0

/* tests/tb_corebus_top.sv */
`include "corebus_cfg.svh"

module tb_corebus_top
  import corebus_pkg::*;
();
  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 4000;

  typedef struct packed {
    cb_opcode_t opcode;
    cb_id_t     id;
    cb_addr_t   addr;
    cb_data_t   wdata;
    cb_status_t exp_status;
    cb_id_t     exp_id;
    cb_data_t   exp_data;
  } entry_t;

  logic       i_clk;
  logic       i_rst_n;
  logic       i_cmd_valid;
  logic       o_cmd_accept;
  cb_opcode_t i_cmd_opcode;
  cb_id_t     i_cmd_id;
  cb_addr_t   i_cmd_addr;
  logic       i_data_valid;
  logic       o_data_accept;
  cb_data_t   i_data;
  logic       o_resp_valid;
  logic       i_resp_accept;
  cb_status_t o_resp_status;
  cb_id_t     o_resp_id;
  cb_data_t   o_resp_data;

  entry_t      table_q[$];
  entry_t      expect_q[$];
  cb_data_t    mem_image [`CB_MEM_DEPTH];
  int          mismatches;
  int          failures;
  int          responses;
  logic [15:0] lfsr;

  corebus_top u_dut (
    .i_clk         (i_clk         ),
    .i_rst_n       (i_rst_n       ),
    .i_cmd_valid   (i_cmd_valid   ),
    .o_cmd_accept  (o_cmd_accept  ),
    .i_cmd_opcode  (i_cmd_opcode  ),
    .i_cmd_id      (i_cmd_id      ),
    .i_cmd_addr    (i_cmd_addr    ),
    .i_data_valid  (i_data_valid  ),
    .o_data_accept (o_data_accept ),
    .i_data        (i_data        ),
    .o_resp_valid  (o_resp_valid  ),
    .i_resp_accept (i_resp_accept ),
    .o_resp_status (o_resp_status ),
    .o_resp_id     (o_resp_id     ),
    .o_resp_data   (o_resp_data   )
  );

  initial begin
    i_clk = 1'b0;
    forever begin
      #50 i_clk = ~i_clk;
    end
  end

  // galois form of x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hb400;
    end else begin
      return state >> 1;
    end
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    mismatches++;
    $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, expected);
  endtask

  // expected values follow the target rules, with a memory image of earlier writes.
  task automatic add_entry(input cb_opcode_t opcode, input cb_addr_t addr,
                           input cb_data_t wdata);
    entry_t e;
    logic   in_range;
    in_range     = int'(addr) < `CB_MEM_DEPTH;
    e.opcode     = opcode;
    e.id         = cb_id_t'(table_q.size());
    e.addr       = addr;
    e.wdata      = wdata;
    e.exp_status = (in_range) ? CB_STATUS_OKAY : CB_STATUS_ERROR;
    e.exp_id     = e.id;
    e.exp_data   = '0;
    if (in_range && (opcode == CB_OPCODE_READ)) begin
      e.exp_data = mem_image[addr];
    end
    if (in_range && (opcode == CB_OPCODE_WRITE)) begin
      mem_image[addr] = wdata;
    end
    table_q.push_back(e);
  endtask

  task automatic build_table();
    for (int a = 0; a < `CB_MEM_DEPTH; a++) begin
      mem_image[a] = '0;
    end
    add_entry(CB_OPCODE_WRITE, 4'd3, 32'ha5a5_0003);
    add_entry(CB_OPCODE_READ, 4'd3, '0);
    add_entry(CB_OPCODE_READ, 4'd7, '0);
    add_entry(CB_OPCODE_WRITE, 4'd1, 32'h1111_0001);
    add_entry(CB_OPCODE_WRITE, 4'd13, 32'hdead_beef);
    add_entry(CB_OPCODE_READ, 4'd13, '0);
    add_entry(CB_OPCODE_READ, 4'd12, '0);
    add_entry(CB_OPCODE_READ, 4'd15, '0);
    // words that an out-of-range write might alias onto must be unchanged.
    add_entry(CB_OPCODE_READ, 4'd1, '0);
    add_entry(CB_OPCODE_READ, 4'd5, '0);
    for (int a = 0; a < `CB_MEM_DEPTH; a++) begin
      add_entry(CB_OPCODE_WRITE, cb_addr_t'(a), 32'hc0de_0000 | 32'(a * 257));
    end
    add_entry(CB_OPCODE_WRITE, 4'd14, 32'hffff_ffff);
    for (int a = `CB_MEM_DEPTH - 1; a >= 0; a--) begin
      add_entry(CB_OPCODE_READ, cb_addr_t'(a), '0);
    end
  endtask

  // accept is a registered output, so its value at the falling edge decides the next rising edge.
  task automatic send_command(input entry_t e);
    int waited;
    waited       = 0;
    i_cmd_valid  = 1'b1;
    i_cmd_opcode = e.opcode;
    i_cmd_id     = e.id;
    i_cmd_addr   = e.addr;
    while (!o_cmd_accept && (waited < WAIT_LIMIT)) begin
      @(negedge i_clk);
      waited++;
    end
    assert (o_cmd_accept) else begin
      failures++;
      $display("command with id 0x%0h was not accepted within %0d cycles", e.id, WAIT_LIMIT);
    end
    expect_q.push_back(e);
    @(negedge i_clk);
    i_cmd_valid = 1'b0;
  endtask

  task automatic send_data(input cb_data_t word);
    int waited;
    waited       = 0;
    i_data_valid = 1'b1;
    i_data       = word;
    while (!o_data_accept && (waited < WAIT_LIMIT)) begin
      @(negedge i_clk);
      waited++;
    end
    assert (o_data_accept) else begin
      failures++;
      $display("write data 0x%0h was not accepted within %0d cycles", word, WAIT_LIMIT);
    end
    @(negedge i_clk);
    i_data_valid = 1'b0;
  endtask

  task automatic drive_entry(input entry_t e);
    if (e.opcode == CB_OPCODE_WRITE) begin
      fork
        send_command(e);
        send_data(e.wdata);
      join
    end else begin
      send_command(e);
    end
  endtask

  task automatic check_response();
    entry_t e;
    assert (expect_q.size() > 0) else begin
      failures++;
      $display("a response arrived at %0t with no command outstanding", $time);
    end
    if (expect_q.size() > 0) begin
      e = expect_q.pop_front();
      assert (o_resp_status == e.exp_status) else
        report_mismatch("o_resp_status", 32'(o_resp_status), 32'(e.exp_status));
      assert (o_resp_id == e.exp_id) else
        report_mismatch("o_resp_id", 32'(o_resp_id), 32'(e.exp_id));
      assert (o_resp_data == e.exp_data) else
        report_mismatch("o_resp_data", o_resp_data, e.exp_data);
    end
    responses++;
  endtask

  // response back-pressure and response checking share the falling edge.
  initial begin
    i_resp_accept = 1'b0;
    lfsr          = 16'd17;
    forever begin
      @(negedge i_clk);
      i_resp_accept = lfsr[0];
      lfsr          = lfsr_next(lfsr);
      if (i_rst_n && o_resp_valid && i_resp_accept) begin
        check_response();
      end
    end
  end

  initial begin
    int waited;
    i_rst_n      = 1'b0;
    i_cmd_valid  = 1'b0;
    i_cmd_opcode = CB_OPCODE_READ;
    i_cmd_id     = '0;
    i_cmd_addr   = '0;
    i_data_valid = 1'b0;
    i_data       = '0;
    mismatches   = 0;
    failures     = 0;
    responses    = 0;
    build_table();
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);
    assert (!o_resp_valid) else report_mismatch("o_resp_valid", 32'(o_resp_valid), 32'd0);
    assert (o_cmd_accept) else report_mismatch("o_cmd_accept", 32'(o_cmd_accept), 32'd1);
    assert (o_data_accept) else report_mismatch("o_data_accept", 32'(o_data_accept), 32'd1);
    foreach (table_q[i]) begin
      drive_entry(table_q[i]);
    end
    waited = 0;
    while ((responses < table_q.size()) && (waited < DRAIN_LIMIT)) begin
      @(negedge i_clk);
      waited++;
    end
    assert (responses == table_q.size()) else begin
      failures++;
      $display("only %0d of %0d responses arrived before the timeout", responses,
               table_q.size());
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if ((mismatches == 0) && (failures == 0)) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end
endmodule

/* rtl/corebus_top.sv */
module corebus_top
  import corebus_pkg::*;
(
  input var logic       i_clk,
  input var logic       i_rst_n,
  input var logic       i_cmd_valid,
  output logic          o_cmd_accept,
  input var cb_opcode_t i_cmd_opcode,
  input var cb_id_t     i_cmd_id,
  input var cb_addr_t   i_cmd_addr,
  input var logic       i_data_valid,
  output logic          o_data_accept,
  input var cb_data_t   i_data,
  output logic          o_resp_valid,
  input var logic       i_resp_accept,
  output cb_status_t    o_resp_status,
  output cb_id_t        o_resp_id,
  output cb_data_t      o_resp_data
);
  logic       tgt_cmd_valid;
  logic       tgt_cmd_accept;
  cb_opcode_t tgt_cmd_opcode;
  cb_id_t     tgt_cmd_id;
  cb_addr_t   tgt_cmd_addr;
  logic       tgt_data_valid;
  logic       tgt_data_accept;
  cb_data_t   tgt_data;
  logic       tgt_resp_valid;
  logic       tgt_resp_accept;
  cb_status_t tgt_resp_status;
  cb_id_t     tgt_resp_id;
  cb_data_t   tgt_resp_data;

  corebus_slicer u_slicer (
    .i_clk              (i_clk            ),
    .i_rst_n            (i_rst_n          ),
    .i_cmd_valid        (i_cmd_valid      ),
    .o_cmd_accept       (o_cmd_accept     ),
    .i_cmd_opcode       (i_cmd_opcode     ),
    .i_cmd_id           (i_cmd_id         ),
    .i_cmd_addr         (i_cmd_addr       ),
    .i_data_valid       (i_data_valid     ),
    .o_data_accept      (o_data_accept    ),
    .i_data             (i_data           ),
    .o_resp_valid       (o_resp_valid     ),
    .i_resp_accept      (i_resp_accept    ),
    .o_resp_status      (o_resp_status    ),
    .o_resp_id          (o_resp_id        ),
    .o_resp_data        (o_resp_data      ),
    .o_tgt_cmd_valid    (tgt_cmd_valid    ),
    .i_tgt_cmd_accept   (tgt_cmd_accept   ),
    .o_tgt_cmd_opcode   (tgt_cmd_opcode   ),
    .o_tgt_cmd_id       (tgt_cmd_id       ),
    .o_tgt_cmd_addr     (tgt_cmd_addr     ),
    .o_tgt_data_valid   (tgt_data_valid   ),
    .i_tgt_data_accept  (tgt_data_accept  ),
    .o_tgt_data         (tgt_data         ),
    .i_tgt_resp_valid   (tgt_resp_valid   ),
    .o_tgt_resp_accept  (tgt_resp_accept  ),
    .i_tgt_resp_status  (tgt_resp_status  ),
    .i_tgt_resp_id      (tgt_resp_id      ),
    .i_tgt_resp_data    (tgt_resp_data    )
  );

  corebus_memory_target u_target (
    .i_clk          (i_clk            ),
    .i_rst_n        (i_rst_n          ),
    .i_cmd_valid    (tgt_cmd_valid    ),
    .o_cmd_accept   (tgt_cmd_accept   ),
    .i_cmd_opcode   (tgt_cmd_opcode   ),
    .i_cmd_id       (tgt_cmd_id       ),
    .i_cmd_addr     (tgt_cmd_addr     ),
    .i_data_valid   (tgt_data_valid   ),
    .o_data_accept  (tgt_data_accept  ),
    .i_data         (tgt_data         ),
    .o_resp_valid   (tgt_resp_valid   ),
    .i_resp_accept  (tgt_resp_accept  ),
    .o_resp_status  (tgt_resp_status  ),
    .o_resp_id      (tgt_resp_id      ),
    .o_resp_data    (tgt_resp_data    )
  );
endmodule

/* rtl/corebus_memory_target.sv */
`include "corebus_cfg.svh"

module corebus_memory_target
  import corebus_pkg::*;
(
  input var logic       i_clk,
  input var logic       i_rst_n,
  input var logic       i_cmd_valid,
  output logic          o_cmd_accept,
  input var cb_opcode_t i_cmd_opcode,
  input var cb_id_t     i_cmd_id,
  input var cb_addr_t   i_cmd_addr,
  input var logic       i_data_valid,
  output logic          o_data_accept,
  input var cb_data_t   i_data,
  output logic          o_resp_valid,
  input var logic       i_resp_accept,
  output cb_status_t    o_resp_status,
  output cb_id_t        o_resp_id,
  output cb_data_t      o_resp_data
);
  localparam int MEM_DEPTH = `CB_MEM_DEPTH;

  cb_target_state_t state;
  cb_opcode_t       cmd_opcode;
  cb_id_t           cmd_id;
  cb_addr_t         cmd_addr;
  cb_data_t         mem [MEM_DEPTH];
  logic             cmd_fire;
  logic             data_fire;
  logic             resp_fire;
  logic             in_range;
  logic             mem_write;

  assign o_cmd_accept  = (state == CB_TARGET_IDLE);
  assign o_data_accept = (state == CB_TARGET_WAIT_DATA);
  assign o_resp_valid  = (state == CB_TARGET_RESPOND);

  assign cmd_fire  = i_cmd_valid && o_cmd_accept;
  assign data_fire = i_data_valid && o_data_accept;
  assign resp_fire = o_resp_valid && i_resp_accept;

  assign in_range  = int'(cmd_addr) < MEM_DEPTH;
  assign mem_write = data_fire && in_range;

  // only an in-range read returns data, every other response carries zero.
  assign o_resp_status = (in_range) ? CB_STATUS_OKAY : CB_STATUS_ERROR;
  assign o_resp_id     = cmd_id;
  assign o_resp_data   = (in_range && (cmd_opcode == CB_OPCODE_READ)) ? mem[cmd_addr] : '0;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= CB_TARGET_IDLE;
    end else begin
      case (state)
        CB_TARGET_IDLE: begin
          if (cmd_fire) begin
            state <= (i_cmd_opcode == CB_OPCODE_WRITE) ? CB_TARGET_WAIT_DATA
                                                       : CB_TARGET_RESPOND;
          end
        end
        CB_TARGET_WAIT_DATA: begin
          if (data_fire) begin
            state <= CB_TARGET_RESPOND;
          end
        end
        CB_TARGET_RESPOND: begin
          if (resp_fire) begin
            state <= CB_TARGET_IDLE;
          end
        end
        default: begin
          state <= CB_TARGET_IDLE;
        end
      endcase
    end
  end

  // the command fields stay put until the response has gone.
  always_ff @(posedge i_clk) begin
    if (cmd_fire) begin
      cmd_opcode <= i_cmd_opcode;
      cmd_id     <= i_cmd_id;
      cmd_addr   <= i_cmd_addr;
    end
  end

  // an out-of-range write still consumes its data beat, memory stays as it was.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (mem_write) begin
      mem[cmd_addr] <= i_data;
    end
  end
endmodule

/* rtl/corebus_slicer.sv */
`include "corebus_cfg.svh"

module corebus_slicer
  import corebus_pkg::*;
(
  input var logic       i_clk,
  input var logic       i_rst_n,
  input var logic       i_cmd_valid,
  output logic          o_cmd_accept,
  input var cb_opcode_t i_cmd_opcode,
  input var cb_id_t     i_cmd_id,
  input var cb_addr_t   i_cmd_addr,
  input var logic       i_data_valid,
  output logic          o_data_accept,
  input var cb_data_t   i_data,
  output logic          o_resp_valid,
  input var logic       i_resp_accept,
  output cb_status_t    o_resp_status,
  output cb_id_t        o_resp_id,
  output cb_data_t      o_resp_data,
  output logic          o_tgt_cmd_valid,
  input var logic       i_tgt_cmd_accept,
  output cb_opcode_t    o_tgt_cmd_opcode,
  output cb_id_t        o_tgt_cmd_id,
  output cb_addr_t      o_tgt_cmd_addr,
  output logic          o_tgt_data_valid,
  input var logic       i_tgt_data_accept,
  output cb_data_t      o_tgt_data,
  input var logic       i_tgt_resp_valid,
  output logic          o_tgt_resp_accept,
  input var cb_status_t i_tgt_resp_status,
  input var cb_id_t     i_tgt_resp_id,
  input var cb_data_t   i_tgt_resp_data
);
  localparam int STAGES     = `CB_SLICER_STAGES;
  localparam int CMD_WIDTH  = $bits(cb_opcode_t) + $bits(cb_id_t) + $bits(cb_addr_t);
  localparam int DATA_WIDTH = $bits(cb_data_t);
  localparam int RESP_WIDTH = $bits(cb_status_t) + $bits(cb_id_t) + $bits(cb_data_t);

  logic [CMD_WIDTH-1:0]  req_cmd;
  logic [CMD_WIDTH-1:0]  tgt_cmd;
  logic [RESP_WIDTH-1:0] tgt_resp;
  logic [RESP_WIDTH-1:0] req_resp;

  assign req_cmd = {i_cmd_opcode, i_cmd_id, i_cmd_addr};
  assign {o_tgt_cmd_opcode, o_tgt_cmd_id, o_tgt_cmd_addr} = tgt_cmd;

  assign tgt_resp = {i_tgt_resp_status, i_tgt_resp_id, i_tgt_resp_data};
  assign {o_resp_status, o_resp_id, o_resp_data} = req_resp;

  corebus_slicer_chain #(
    .WIDTH  (CMD_WIDTH  ),
    .STAGES (STAGES     )
  ) u_command_slicer (
    .i_clk    (i_clk            ),
    .i_rst_n  (i_rst_n          ),
    .i_valid  (i_cmd_valid      ),
    .o_ready  (o_cmd_accept     ),
    .i_data   (req_cmd          ),
    .o_valid  (o_tgt_cmd_valid  ),
    .i_ready  (i_tgt_cmd_accept ),
    .o_data   (tgt_cmd          )
  );

  corebus_slicer_chain #(
    .WIDTH  (DATA_WIDTH ),
    .STAGES (STAGES     )
  ) u_write_data_slicer (
    .i_clk    (i_clk              ),
    .i_rst_n  (i_rst_n            ),
    .i_valid  (i_data_valid       ),
    .o_ready  (o_data_accept      ),
    .i_data   (i_data             ),
    .o_valid  (o_tgt_data_valid   ),
    .i_ready  (i_tgt_data_accept  ),
    .o_data   (o_tgt_data         )
  );

  // responses run from the target back towards the requester.
  corebus_slicer_chain #(
    .WIDTH  (RESP_WIDTH ),
    .STAGES (STAGES     )
  ) u_response_slicer (
    .i_clk    (i_clk              ),
    .i_rst_n  (i_rst_n            ),
    .i_valid  (i_tgt_resp_valid   ),
    .o_ready  (o_tgt_resp_accept  ),
    .i_data   (tgt_resp           ),
    .o_valid  (o_resp_valid       ),
    .i_ready  (i_resp_accept      ),
    .o_data   (req_resp           )
  );
endmodule

/* rtl/corebus_slicer_chain.sv */
module corebus_slicer_chain #(
  parameter int WIDTH  = 1,
  parameter int STAGES = 1
)(
  input var logic             i_clk,
  input var logic             i_rst_n,
  input var logic             i_valid,
  output logic                o_ready,
  input var logic [WIDTH-1:0] i_data,
  output logic                o_valid,
  input var logic             i_ready,
  output logic [WIDTH-1:0]    o_data
);
  if (STAGES == 0) begin : g_bypass
    assign o_valid = i_valid;
    assign o_ready = i_ready;
    assign o_data  = i_data;
  end else begin : g_stages
    // index 0 is the chain input, index STAGES the chain output.
    logic [STAGES:0]  valid;
    logic [STAGES:0]  ready;
    logic [WIDTH-1:0] data [STAGES+1];

    assign valid[0]      = i_valid;
    assign o_ready       = ready[0];
    assign data[0]       = i_data;
    assign o_valid       = valid[STAGES];
    assign ready[STAGES] = i_ready;
    assign o_data        = data[STAGES];

    for (genvar i = 0; i < STAGES; i++) begin : g_stage
      corebus_slice_stage #(
        .WIDTH  (WIDTH)
      ) u_stage (
        .i_clk    (i_clk      ),
        .i_rst_n  (i_rst_n    ),
        .i_valid  (valid[i]   ),
        .o_ready  (ready[i]   ),
        .i_data   (data[i]    ),
        .o_valid  (valid[i+1] ),
        .i_ready  (ready[i+1] ),
        .o_data   (data[i+1]  )
      );
    end
  end
endmodule

/* rtl/corebus_slice_stage.sv */
module corebus_slice_stage #(
  parameter int WIDTH = 1
)(
  input var logic             i_clk,
  input var logic             i_rst_n,
  input var logic             i_valid,
  output logic                o_ready,
  input var logic [WIDTH-1:0] i_data,
  output logic                o_valid,
  input var logic             i_ready,
  output logic [WIDTH-1:0]    o_data
);
  logic             main_valid;
  logic [WIDTH-1:0] main_data;
  logic             skid_valid;
  logic [WIDTH-1:0] skid_data;
  logic             in_fire;
  logic             main_load;
  logic             skid_load;

  // input accept only looks at the skid flag, so it is a flop output.
  assign o_ready = !skid_valid;
  assign o_valid = main_valid;
  assign o_data  = main_data;

  assign in_fire = i_valid && !skid_valid;

  // the main register can take a beat when it is empty or draining.
  assign main_load = !main_valid || i_ready;

  // a beat that arrives while the output is stalled parks in the skid entry.
  assign skid_load = in_fire && !main_load;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (main_load) begin
        main_valid <= skid_valid || in_fire;
      end
      if (skid_load) begin
        skid_valid <= 1'b1;
      end else if (main_load) begin
        skid_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (main_load) begin
      main_data <= (skid_valid) ? skid_data : i_data;
    end
    if (skid_load) begin
      skid_data <= i_data;
    end
  end
endmodule

/* rtl/corebus_pkg.sv */
package corebus_pkg;
  `include "corebus_cfg.svh"

  typedef logic cb_opcode_t;

  localparam cb_opcode_t CB_OPCODE_READ  = 1'b0;
  localparam cb_opcode_t CB_OPCODE_WRITE = 1'b1;

  typedef logic [`CB_ID_WIDTH-1:0] cb_id_t;

  typedef logic [`CB_ADDR_WIDTH-1:0] cb_addr_t;

  typedef logic [`CB_DATA_WIDTH-1:0] cb_data_t;

  typedef logic cb_status_t;

  localparam cb_status_t CB_STATUS_OKAY  = 1'b0;
  localparam cb_status_t CB_STATUS_ERROR = 1'b1;

  // the target takes one command at a time, a write waits for its data beat.
  typedef enum logic [1:0] {
    CB_TARGET_IDLE,
    CB_TARGET_WAIT_DATA,
    CB_TARGET_RESPOND
  } cb_target_state_t;
endpackage

/* rtl/corebus_cfg.svh */
`ifndef COREBUS_CFG_SVH
`define COREBUS_CFG_SVH

// word address width.
`define CB_ADDR_WIDTH 4

// data word width.
`define CB_DATA_WIDTH 32

// command id width.
`define CB_ID_WIDTH 4

// number of implemented words. An address at or above it is out of range.
`define CB_MEM_DEPTH 12

// register stages on every channel of the slicer.
`define CB_SLICER_STAGES 2

`endif
